// ==== design/cpuPkg.sv ====
// shared widths, opcodes, function codes, memory sizes, types and memory fsm states
package cpuPkg;

        ////////////////////////////////////////
        // types
        typedef logic [15:0] wordT;             // data word and byte address
        typedef logic [15:0] instrT;
        typedef logic [2:0]  regIdxT;           // r0..r7
        typedef logic [4:0]  opcodeT;           // instr[15:11]
        typedef logic [1:0]  funcT;             // instr[1:0], r-format only
        typedef logic [1:0]  fwdSelT;

        typedef enum logic [1:0] {
                memIdle,
                memWait,
                memDone
        } memStateT;

        // forwarding selects, 2'b11 is reserved
        localparam fwdSelT FwdIdEx  = 2'd0;     // value read in decode
        localparam fwdSelT FwdExMem = 2'd1;
        localparam fwdSelT FwdWb    = 2'd2;

        ////////////////////////////////////////
        // opcodes
        localparam opcodeT OpHalt  = 5'b00000;
        localparam opcodeT OpNop   = 5'b00001;
        localparam opcodeT OpJ     = 5'b00100;
        localparam opcodeT OpAddi  = 5'b01000;
        localparam opcodeT OpBeqz  = 5'b01100;
        localparam opcodeT OpSt    = 5'b10000;
        localparam opcodeT OpLd    = 5'b10001;
        localparam opcodeT OpRType = 5'b11011;

        localparam funcT FnAdd  = 2'b00;        // rs + rt
        localparam funcT FnSub  = 2'b01;        // rt - rs
        localparam funcT FnXor  = 2'b10;
        localparam funcT FnAndn = 2'b11;        // rs & ~rt

        localparam instrT NopInstr = {OpNop, 11'b0};    // pipeline bubble

        ////////////////////////////////////////
        // memories
        localparam int ImemWords    = 256;
        localparam int DmemWords    = 256;
        localparam int MemLatency   = 2;        // extra cycles per data access
        localparam int ImemAddrBits = $clog2(ImemWords);
        localparam int DmemAddrBits = $clog2(DmemWords);
        localparam int MemCntBits   = $clog2(MemLatency + 1);

        // anything outside the implemented set traps at writeback
        function automatic logic isLegal(opcodeT op);
                case (op)
                        OpHalt, OpNop, OpJ, OpAddi, OpBeqz, OpSt, OpLd, OpRType: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

endpackage

// ==== design/regFile.sv ====
// eight-entry register file, two read ports, one write port, write-through
module regFile import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        input  regIdxT rdAddrA,
        input  regIdxT rdAddrB,
        output wordT   rdDataA,
        output wordT   rdDataB,
        input  logic   wrEn,
        input  regIdxT wrAddr,
        input  wordT   wrData
);
        wordT regs [8];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        for (int i = 0; i < 8; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wrEn) begin
                        regs[wrAddr] <= wrData;
                end
        end

        // same-cycle write wins over the stored value
        assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
        assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== design/fetchStage.sv ====
// program counter, instruction rom, redirect and if/id register
module fetchStage import cpuPkg::*; (
        input  logic  clk,
        input  logic  rstN,
        input  logic  hold,             // stall, memBusy or halted
        input  logic  flush,
        input  logic  redirect,
        input  wordT  redirectPc,
        output logic  stopFetch,
        output instrT ifInstr,
        output wordT  ifPcNext
);
        wordT  pc;
        instrT rom [ImemWords];
        instrT fetched;
        logic  fetchStop;

        initial $readmemh("program.hex", rom);

        assign fetched = rom[pc[ImemAddrBits:1]];      // pc is a byte address
        // halt or illegal ends the instruction stream
        assign fetchStop = (fetched[15:11] == OpHalt) || !isLegal(fetched[15:11]);

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        pc <= '0;
                        stopFetch <= 1'b0;
                        ifInstr <= NopInstr;
                end else if (!hold) begin
                        if (redirect) begin
                                pc <= redirectPc;
                                stopFetch <= 1'b0;      // a flushed halt never counts
                        end else if (!stopFetch) begin
                                pc <= pc + 16'd2;
                                stopFetch <= fetchStop;
                        end
                        if (flush || stopFetch) ifInstr <= NopInstr;
                        else ifInstr <= fetched;
                end
        end

        always_ff @(posedge clk) begin
                if (!hold) ifPcNext <= pc + 16'd2;     // base for branch targets
        end

endmodule

// ==== design/decodeStage.sv ====
// instruction decode, immediate extension, illegal opcode flag and id/ex register
module decodeStage import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        input  logic   hold,
        input  logic   flush,
        input  instrT  ifInstr,
        input  wordT   ifPcNext,
        input  logic   wbEn,
        input  regIdxT wbReg,
        input  wordT   wbData,
        output instrT  idInstr,
        output wordT   idPcNext,
        output wordT   idA,
        output wordT   idB,
        output wordT   idImm,
        output regIdxT idRs,
        output regIdxT idRt,
        output regIdxT idDst,
        output logic   idRegWrite,
        output logic   idMemRead,
        output logic   idMemWrite,
        output logic   idHalt,
        output logic   idIllegal
);
        opcodeT op;
        wordT   rdA;
        wordT   rdB;
        wordT   imm;
        regIdxT dst;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;

        assign op = ifInstr[15:11];

        regFile regFile_i (
                .clk(clk), .rstN(rstN),
                .rdAddrA(ifInstr[10:8]), .rdAddrB(ifInstr[7:5]),
                .rdDataA(rdA), .rdDataB(rdB),
                .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData)
        );

        always_comb begin
                regWrite = (op == OpRType) || (op == OpAddi) || (op == OpLd);
                memRead = (op == OpLd);
                memWrite = (op == OpSt);
                dst = (op == OpRType) ? ifInstr[4:2] : ifInstr[7:5];   // addi/ld target rt
                case (op)
                        OpAddi, OpLd, OpSt: imm = {{11{ifInstr[4]}}, ifInstr[4:0]};
                        OpBeqz: imm = {{8{ifInstr[7]}}, ifInstr[7:0]};
                        OpJ: imm = {{5{ifInstr[10]}}, ifInstr[10:0]};
                        default: imm = '0;
                endcase
        end

        ////////////////////////////////////////
        // id/ex register, bubble on stall or redirect
        always_ff @(posedge clk) begin
                if (!rstN || (!hold && flush)) begin
                        idInstr <= NopInstr;
                        {idRegWrite, idMemRead, idMemWrite, idHalt, idIllegal} <= '0;
                end else if (!hold) begin
                        idInstr <= ifInstr;
                        idRegWrite <= regWrite;
                        idMemRead <= memRead;
                        idMemWrite <= memWrite;
                        idHalt <= (op == OpHalt);
                        idIllegal <= !isLegal(op);
                end
        end

        always_ff @(posedge clk) begin
                if (!hold) begin
                        {idPcNext, idA, idB, idImm} <= {ifPcNext, rdA, rdB, imm};
                        {idRs, idRt, idDst} <= {ifInstr[10:8], ifInstr[7:5], dst};
                end
        end

endmodule

// ==== design/hazardUnit.sv ====
// load-use stall detection and execute operand forwarding selects
module hazardUnit import cpuPkg::*; (
        input  instrT  ifInstr,
        input  logic   idMemRead,
        input  regIdxT idDst,
        input  regIdxT idRs,
        input  regIdxT idRt,
        input  logic   exRegWrite,
        input  regIdxT exDst,
        input  logic   wbEn,
        input  regIdxT wbReg,
        output logic   stall,
        output fwdSelT fwdA,
        output fwdSelT fwdB
);
        opcodeT ifOp;
        logic   usesRs;
        logic   usesRt;

        assign ifOp = ifInstr[15:11];
        assign usesRs = (ifOp == OpRType) || (ifOp == OpSt) || (ifOp == OpAddi)
                     || (ifOp == OpLd) || (ifOp == OpBeqz);
        assign usesRt = (ifOp == OpRType) || (ifOp == OpSt);      // st data is rt

        // load in id/ex feeding the very next instruction
        assign stall = idMemRead && ((usesRs && idDst == ifInstr[10:8])
                                  || (usesRt && idDst == ifInstr[7:5]));

        // youngest producer first
        function automatic fwdSelT pickFwd(regIdxT src);
                if (exRegWrite && exDst == src) return FwdExMem;
                if (wbEn && wbReg == src) return FwdWb;
                return FwdIdEx;
        endfunction

        assign fwdA = pickFwd(idRs);
        assign fwdB = pickFwd(idRt);

endmodule

// ==== design/executeStage.sv ====
// forwarding muxes, alu, branch/jump resolution and ex/mem register
module executeStage import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        input  logic   hold,
        input  instrT  idInstr,
        input  wordT   idPcNext,
        input  wordT   idA,
        input  wordT   idB,
        input  wordT   idImm,
        input  regIdxT idDst,
        input  logic   idRegWrite,
        input  logic   idMemRead,
        input  logic   idMemWrite,
        input  logic   idHalt,
        input  logic   idIllegal,
        input  fwdSelT fwdA,
        input  fwdSelT fwdB,
        input  wordT   wbData,
        output logic   redirect,
        output wordT   redirectPc,
        output wordT   exAlu,
        output wordT   exStore,
        output regIdxT exDst,
        output logic   exRegWrite,
        output logic   exMemRead,
        output logic   exMemWrite,
        output logic   exHalt,
        output logic   exIllegal
);
        opcodeT op;
        wordT   liveA;
        wordT   liveB;
        wordT   heldA;
        wordT   heldB;
        wordT   opA;
        wordT   opB;
        wordT   aluOut;
        logic   heldValid;

        function automatic wordT fwdMux(fwdSelT sel, wordT idVal);
                case (sel)
                        FwdExMem: return exAlu;
                        FwdWb: return wbData;
                        default: return idVal;
                endcase
        endfunction

        assign op = idInstr[15:11];
        assign liveA = fwdMux(fwdA, idA);
        assign liveB = fwdMux(fwdB, idB);
        // mem/wb empties during a memory stall, keep what was forwarded
        assign opA = heldValid ? heldA : liveA;
        assign opB = heldValid ? heldB : liveB;

        always_comb begin
                case (op)
                        OpRType: case (funcT'(idInstr[1:0]))
                                FnAdd: aluOut = opA + opB;
                                FnSub: aluOut = opB - opA;
                                FnXor: aluOut = opA ^ opB;
                                default: aluOut = opA & ~opB;     // andn
                        endcase
                        OpAddi, OpLd, OpSt: aluOut = opA + idImm;     // sum or address
                        default: aluOut = '0;
                endcase
        end

        assign redirect = (op == OpJ) || (op == OpBeqz && opA == '0);
        assign redirectPc = idPcNext + idImm;

        always_ff @(posedge clk) begin
                if (!rstN || !hold) heldValid <= 1'b0;
                else heldValid <= 1'b1;
        end

        always_ff @(posedge clk) begin
                if (hold && !heldValid) {heldA, heldB} <= {liveA, liveB};  // first frozen cycle
        end

        ////////////////////////////////////////
        // ex/mem register
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        {exRegWrite, exMemRead, exMemWrite, exHalt, exIllegal} <= '0;
                end else if (!hold) begin
                        {exRegWrite, exMemRead, exMemWrite} <= {idRegWrite, idMemRead, idMemWrite};
                        {exHalt, exIllegal} <= {idHalt, idIllegal};
                end
        end

        always_ff @(posedge clk) begin
                if (!hold) {exAlu, exStore, exDst} <= {aluOut, opB, idDst};    // st data is rt
        end

endmodule

// ==== design/memoryStage.sv ====
// data memory fsm with wait counter, alignment check, mem/wb register, halt and error status
module memoryStage import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        input  wordT   exAlu,
        input  wordT   exStore,
        input  regIdxT exDst,
        input  logic   exRegWrite,
        input  logic   exMemRead,
        input  logic   exMemWrite,
        input  logic   exHalt,
        input  logic   exIllegal,
        output logic   memBusy,
        output logic   wbEn,
        output regIdxT wbReg,
        output wordT   wbData,
        output logic   halted,
        output logic   err
);
        memStateT                state;
        logic [MemCntBits-1:0]   waitCnt;
        wordT                    dmem [DmemWords];
        logic [DmemAddrBits-1:0] addr;
        wordT                    loadData;
        logic                    memOp;
        logic                    unaligned;
        logic                    stopping;
        logic                    access;
        logic                    wbHalt;
        logic                    wbErr;

        assign addr = exAlu[DmemAddrBits:1];           // word index
        assign memOp = exMemRead | exMemWrite;
        assign unaligned = memOp & exAlu[0];
        // nothing younger than a halt or trap may touch memory
        assign stopping = halted | wbHalt | wbErr;
        assign access = memOp & ~unaligned & ~stopping;
        assign memBusy = (state == memWait) || (state == memIdle && access);
        assign loadData = dmem[addr];

        ////////////////////////////////////////
        // access timing
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        state <= memIdle;
                        waitCnt <= '0;
                end else begin
                        case (state)
                                memIdle: if (access) begin
                                        waitCnt <= MemCntBits'(1);     // first busy cycle
                                        state <= (MemLatency == 1) ? memDone : memWait;
                                end
                                memWait: begin
                                        waitCnt <= waitCnt + 1'b1;
                                        if (waitCnt == MemCntBits'(MemLatency - 1)) state <= memDone;
                                end
                                default: state <= memIdle;      // done, pipe moves on
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == memDone && exMemWrite) dmem[addr] <= exStore;
        end

        ////////////////////////////////////////
        // mem/wb register
        always_ff @(posedge clk) begin
                if (!rstN || memBusy || stopping) begin
                        {wbEn, wbHalt, wbErr} <= '0;    // bubble
                end else begin
                        wbEn <= exRegWrite & ~unaligned;
                        wbHalt <= exHalt;
                        wbErr <= exIllegal | unaligned;
                end
        end

        always_ff @(posedge clk) begin
                if (!memBusy) begin
                        wbReg <= exDst;
                        wbData <= exMemRead ? loadData : exAlu;
                end
        end

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        halted <= 1'b0;
                        err <= 1'b0;
                end else if (!halted && (wbHalt || wbErr)) begin
                        halted <= 1'b1;         // sticky until reset
                        err <= wbErr;
                end
        end

        assert property (@(posedge clk) disable iff (!rstN)
                $rose(memBusy) |-> memBusy [*MemLatency] ##1 !memBusy)
                else $error("data memory busy for the wrong number of cycles");

endmodule

// ==== design/cpuTop.sv ====
// processor top level, stage instances, hold and flush nets, status and writeback ports
module cpuTop import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        output logic   halted,
        output logic   err,
        output logic   wbEn,
        output regIdxT wbReg,
        output wordT   wbData
);
        logic   stall, memBusy, redirect, stopFetch;
        logic   pipeHold, fetchHold, idFlush;
        wordT   redirectPc;
        fwdSelT fwdA, fwdB;
        // if/id
        instrT  ifInstr;
        wordT   ifPcNext;
        // id/ex
        instrT  idInstr;
        wordT   idPcNext, idA, idB, idImm;
        regIdxT idRs, idRt, idDst;
        logic   idRegWrite, idMemRead, idMemWrite, idHalt, idIllegal;
        // ex/mem
        wordT   exAlu, exStore;
        regIdxT exDst;
        logic   exRegWrite, exMemRead, exMemWrite, exHalt, exIllegal;

        assign pipeHold = memBusy | halted;             // freezes every stage
        assign fetchHold = pipeHold | stall;
        assign idFlush = stall | redirect;

        fetchStage fetchStage_i (
                .clk(clk), .rstN(rstN), .hold(fetchHold), .flush(redirect),
                .redirect(redirect), .redirectPc(redirectPc), .stopFetch(stopFetch),
                .ifInstr(ifInstr), .ifPcNext(ifPcNext)
        );

        decodeStage decodeStage_i (
                .clk(clk), .rstN(rstN), .hold(pipeHold), .flush(idFlush),
                .ifInstr(ifInstr), .ifPcNext(ifPcNext),
                .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
                .idInstr(idInstr), .idPcNext(idPcNext), .idA(idA), .idB(idB), .idImm(idImm),
                .idRs(idRs), .idRt(idRt), .idDst(idDst), .idRegWrite(idRegWrite),
                .idMemRead(idMemRead), .idMemWrite(idMemWrite),
                .idHalt(idHalt), .idIllegal(idIllegal)
        );

        hazardUnit hazardUnit_i (
                .ifInstr(ifInstr), .idMemRead(idMemRead), .idDst(idDst),
                .idRs(idRs), .idRt(idRt), .exRegWrite(exRegWrite), .exDst(exDst),
                .wbEn(wbEn), .wbReg(wbReg), .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
        );

        executeStage executeStage_i (
                .clk(clk), .rstN(rstN), .hold(pipeHold),
                .idInstr(idInstr), .idPcNext(idPcNext), .idA(idA), .idB(idB), .idImm(idImm),
                .idDst(idDst), .idRegWrite(idRegWrite), .idMemRead(idMemRead),
                .idMemWrite(idMemWrite), .idHalt(idHalt), .idIllegal(idIllegal),
                .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
                .redirect(redirect), .redirectPc(redirectPc),
                .exAlu(exAlu), .exStore(exStore), .exDst(exDst), .exRegWrite(exRegWrite),
                .exMemRead(exMemRead), .exMemWrite(exMemWrite),
                .exHalt(exHalt), .exIllegal(exIllegal)
        );

        memoryStage memoryStage_i (
                .clk(clk), .rstN(rstN),
                .exAlu(exAlu), .exStore(exStore), .exDst(exDst), .exRegWrite(exRegWrite),
                .exMemRead(exMemRead), .exMemWrite(exMemWrite),
                .exHalt(exHalt), .exIllegal(exIllegal), .memBusy(memBusy),
                .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
        );

        // a clean halt is only reached after fetch has seen the halt word
        assert property (@(posedge clk) disable iff (!rstN) (halted && !err) |-> stopFetch)
                else $error("halted without fetch stopped");

endmodule

// ==== verification/isaModel.svh ====
// in-order instruction model, program image, data memory and expected commit list
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam instrT IllegalWord   = {5'b11111, 11'b0};   // replaces halt in run 2
localparam int    MaxModelSteps = 4 * ImemWords;        // runaway guard

instrT  progImg [ImemWords];
wordT   dataMem [DmemWords];
bit     dataKnown [DmemWords];          // stored at least once
regIdxT expReg [MaxModelSteps];
wordT   expVal [MaxModelSteps];
int     expCount;
bit     expErr;
logic [ImemAddrBits-1:0] haltIdx;       // word of the halt that ran 1 reached

task automatic addCommit(input regIdxT r, input wordT v);
        expReg[expCount] = r;
        expVal[expCount] = v;
        expCount++;
endtask

// walk the program one instruction at a time, straight from the field rules
task automatic buildExpected(input bit patchHalt);
        wordT   regs [8];
        wordT   pc;
        wordT   a;
        wordT   b;
        wordT   addr;
        wordT   res;
        instrT  ir;
        logic [ImemAddrBits-1:0] idx;
        int     steps;
        bit     done;

        $readmemh("program.hex", progImg);
        if (patchHalt) progImg[haltIdx] = IllegalWord;
        foreach (regs[i]) regs[i] = '0;
        foreach (dataKnown[i]) dataKnown[i] = 1'b0;
        expCount = 0;
        expErr = 1'b0;
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done) begin
                idx = pc[ImemAddrBits:1];
                ir = progImg[idx];
                a = regs[ir[10:8]];             // rs
                b = regs[ir[7:5]];              // rt
                addr = a + {{11{ir[4]}}, ir[4:0]};      // also the addi sum
                pc = pc + 16'd2;                // branch base
                steps++;
                case (ir[15:11])
                        OpHalt: begin
                                done = 1'b1;
                                if (!patchHalt) haltIdx = idx;
                        end
                        OpNop: ;
                        OpJ: pc = pc + {{5{ir[10]}}, ir[10:0]};
                        OpBeqz: if (a == '0) pc = pc + {{8{ir[7]}}, ir[7:0]};
                        OpAddi: begin
                                regs[ir[7:5]] = addr;
                                addCommit(ir[7:5], addr);
                        end
                        OpSt, OpLd: begin
                                if (addr[0]) begin
                                        expErr = 1'b1;  // unaligned traps
                                        done = 1'b1;
                                end else if (ir[15:11] == OpSt) begin
                                        dataMem[addr[DmemAddrBits:1]] = b;
                                        dataKnown[addr[DmemAddrBits:1]] = 1'b1;
                                end else if (!dataKnown[addr[DmemAddrBits:1]]) begin
                                        abortRun("model loads a data word the program never stored");
                                end else begin
                                        regs[ir[7:5]] = dataMem[addr[DmemAddrBits:1]];
                                        addCommit(ir[7:5], dataMem[addr[DmemAddrBits:1]]);
                                end
                        end
                        OpRType: begin
                                case (ir[1:0])
                                        FnAdd: res = a + b;
                                        FnSub: res = b - a;     // rt minus rs
                                        FnXor: res = a ^ b;
                                        default: res = a & ~b;
                                endcase
                                regs[ir[4:2]] = res;
                                addCommit(ir[4:2], res);
                        end
                        default: begin
                                expErr = 1'b1;  // illegal opcode
                                done = 1'b1;
                        end
                endcase
                if (!done && steps >= MaxModelSteps) abortRun("model never reached a halt");
        end
endtask

`endif

// ==== verification/cpuTb.sv ====
// testbench for the pipelined cpu, clock, reset, two program runs, watchdog, commit checks
module cpuTb import cpuPkg::*; ();
        logic   clk;
        logic   rstN;
        logic   halted;
        logic   err;
        logic   wbEn;
        regIdxT wbReg;
        wordT   wbData;
        int     commitIdx;              // next expected entry
        int     watchCycles;

        cpuTop cpuTop_i (
                .clk(clk), .rstN(rstN), .halted(halted), .err(err),
                .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
        );

        `include "isaModel.svh"

        ////////////////////////////////////////
        // failure reporting
        task automatic failNow();
                $display("RESULT: FAIL");
                $fatal(1);
        endtask

        task automatic abortRun(input string why);
                $display("ERROR at time %0t: %s", $time, why);
                failNow();
        endtask

        task automatic showMismatch(input string sig, input wordT expected, input wordT actual);
                $display("MISMATCH at time %0t: %s expected %h got %h",
                         $time, sig, expected, actual);
                failNow();
        endtask

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        ////////////////////////////////////////
        // commit stream, sampled mid-cycle
        always @(negedge clk) begin
                if (!rstN) begin
                        commitIdx <= 0;
                end else if (wbEn) begin
                        commitIdx <= commitIdx + 1;
                        if (commitIdx >= expCount) begin
                                abortRun("a commit arrived after the expected list ended");
                        end else begin
                                assert (wbReg == expReg[commitIdx] && wbData == expVal[commitIdx])
                                else if (wbReg != expReg[commitIdx])
                                        showMismatch("wbReg", 16'(expReg[commitIdx]), 16'(wbReg));
                                else
                                        showMismatch("wbData", expVal[commitIdx], wbData);
                        end
                end
        end

        // status rules
        assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbEn)
                else abortRun("a commit appeared while halted");
        assert property (@(posedge clk) disable iff (!rstN) $rose(err) |-> $rose(halted))
                else abortRun("err rose without halted rising in the same cycle");
        assert property (@(posedge clk) disable iff (!rstN) halted |-> err == expErr)
                else showMismatch("err", 16'(expErr), 16'(err));
        // every expected commit is in before the halt shows
        assert property (@(posedge clk) disable iff (!rstN)
                $rose(halted) |-> commitIdx == expCount)
                else showMismatch("commit count at halt", 16'(expCount), 16'(commitIdx));

        // release reset, wait for halt, then a quiet stretch
        task automatic runProgram();
                repeat (2) @(posedge clk);
                #1 rstN = 1'b1;
                do @(negedge clk); while (!halted);
                repeat (8) @(negedge clk);      // late commits would trip the checks
                assert (commitIdx == expCount)
                        else showMismatch("commit count", 16'(expCount), 16'(commitIdx));
        endtask

        ////////////////////////////////////////
        // main sequence
        initial begin
                rstN = 1'b0;
                buildExpected(1'b0);
                watchCycles = 2 * 40 * (int'(haltIdx) + 1);     // two runs
                runProgram();
                // run 2, halt word turned into an illegal opcode
                @(posedge clk);
                #1 rstN = 1'b0;
                cpuTop_i.fetchStage_i.rom[haltIdx] = IllegalWord;
                buildExpected(1'b1);
                runProgram();
                $display("RESULT: PASS");
                $finish;
        end

        initial begin
                #1;                             // budget known after the first model pass
                repeat (watchCycles) @(posedge clk);
                abortRun("watchdog expired before both runs reached halted");
        end

endmodule

// ==== program.hex ====
// one instruction word per line, starting at word 0
// opcode[15:11] rs[10:8] rt[7:5], then imm5[4:0] or rd[4:2] fn[1:0]
4025 // addi r1, r0, 5
4143 // addi r2, r1, 3      back to back
D94C // add  r3, r1, r2
D971 // sub  r4 = r3 - r1
DB96 // xor  r5, r3, r4
DB3B // andn r6 = r3 & ~r1
82A2 // st   r5, [r2 + 2]
82C4 // st   r6, [r2 + 4]
8AE2 // ld   r7, [r2 + 2]
DFE4 // add  r1, r7, r7     load use
8C64 // ld   r3, [r4 + 4]
425E // addi r2, r2, -2
DA71 // sub  r4 = r3 - r2   load one apart
6404 // beqz r4, +4         not taken
DC9A // xor  r6, r4, r4
6604 // beqz r6, +4         taken
4121 // addi r1, r1, 1      skipped
4241 // addi r2, r2, 1      skipped
2002 // j    +2
45A1 // addi r5, r5, 1      skipped
41A7 // addi r5, r1, 7
0000 // halt

// ==== sim.f ====
+incdir+verification
design/cpuPkg.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
verification/cpuTb.sv

// ==== Makefile ====
SOURCES = $(filter-out +incdir+%,$(shell cat sim.f)) verification/isaModel.svh

obj_dir/VcpuTb: $(SOURCES) sim.f
	verilator --binary --timing --assert --top-module cpuTb -f sim.f

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb 2>&1 | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
